// File: all.f
+incdir+include
hdl/mxu_pkg.sv
hdl/mxu_mac.sv
hdl/mxu_core.sv
hdl/mxu_skew.sv
hdl/mxu_weight_buf.sv
hdl/mxu_ctrl.sv
hdl/mxu_top.sv
verification/mxu_props.sv
verification/mxu_tb.sv

// File: hdl/mxu_core.sv
`include "mxu_macros.svh"

module mxu_core (
   input  logic                              clk,
   input  logic                              rst_n,
   input  logic                              enable,
   input  mxu_pkg::precision_e               prec,
   input  logic [`MXU_COLS*`MXU_WIDTH-1:0]   input_data,
   input  logic [`MXU_ROWS*`MXU_WIDTH-1:0]   weight,
   output logic [`MXU_ROWS*`MXU_WIDTH-1:0]   y
);
   localparam int R = `MXU_ROWS;
   localparam int C = `MXU_COLS;
   localparam int W = `MXU_WIDTH;

   // data_down[i][j]: column j as seen by row i
   logic [W-1:0] data_down [R][C];
   // psum[i][j]: partial sum entering column j of row i
   logic [W-1:0] psum      [R][C+1];

   //////////////////////////////
   // grid edges
   //////////////////////////////

   for (genvar j = 0; j < C; j++) begin : g_top_edge
      assign data_down[0][j] = input_data[j*W +: W];
   end

   for (genvar i = 0; i < R; i++) begin : g_side_edge
      assign psum[i][0]     = '0;
      assign y[i*W +: W]    = psum[i][C]; // last column leaves the array
   end

   //////////////////////////////
   // cells
   //////////////////////////////

   for (genvar i = 0; i < R; i++) begin : g_row
      for (genvar j = 0; j < C; j++) begin : g_col
         localparam int acc = (j == 0) ? 0 : 1;

         if (i == R - 1) begin : g_last
            // bottom row, data stops here
            mxu_mac #(
               .accumulate(acc)
            ) mac_i (
               .clk                 (clk),
               .rst_n               (rst_n),
               .enable              (enable),
               .prec                (prec),
               .data_input          (data_down[i][j]),
               .weight              (weight[i*W +: W]),
               .res_mac_p           (psum[i][j]),
               .res_mac_n           (psum[i][j+1]),
               .data_input_next_row ()
            );
         end else begin : g_inner
            mxu_mac #(
               .accumulate(acc)
            ) mac_i (
               .clk                 (clk),
               .rst_n               (rst_n),
               .enable              (enable),
               .prec                (prec),
               .data_input          (data_down[i][j]),
               .weight              (weight[i*W +: W]), // row weight, broadcast
               .res_mac_p           (psum[i][j]),
               .res_mac_n           (psum[i][j+1]),
               .data_input_next_row (data_down[i+1][j])
            );
         end
      end
   end

endmodule

// File: hdl/mxu_ctrl.sv
`include "mxu_macros.svh"

module mxu_ctrl (
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic                  enable,
   input  logic                  in_valid,
   input  mxu_pkg::precision_e   data_type,
   output mxu_pkg::precision_e   prec,
   output logic                  out_valid,
   output logic                  busy
);
   import mxu_pkg::*;

   localparam int L = `MXU_LATENCY;

   logic [L-1:0] vld_pipe; // one bit per vector in flight

   //////////////////////////////
   // valid pipeline
   //////////////////////////////

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         vld_pipe <= '0;
      end else if (enable) begin
         vld_pipe <= {vld_pipe[L-2:0], in_valid};
      end
   end

   assign out_valid = vld_pipe[L-1];  // lines up with the deskewed rows
   assign busy      = |vld_pipe;

   //////////////////////////////
   // precision latch
   //////////////////////////////

   // the first cell already computes on the edge that latches a new mode,
   // so change data_type at least one idle cycle before the next vector
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         prec <= PREC_FULL;
      end else if (enable && !busy) begin
         prec <= data_type;
      end
   end

endmodule

// File: hdl/mxu_mac.sv
`include "mxu_macros.svh"

module mxu_mac #(
   parameter int accumulate = 1 // 0 only in the first column
) (
   input  logic                   clk,
   input  logic                   rst_n,
   input  logic                   enable,
   input  mxu_pkg::precision_e    prec,
   input  logic [`MXU_WIDTH-1:0]  data_input,
   input  logic [`MXU_WIDTH-1:0]  weight,
   input  logic [`MXU_WIDTH-1:0]  res_mac_p,
   output logic [`MXU_WIDTH-1:0]  res_mac_n,
   output logic [`MXU_WIDTH-1:0]  data_input_next_row
);
   import mxu_pkg::*;

   localparam int W = `MXU_WIDTH;
   localparam int H = W / 2;

   logic [H-1:0] prod_lo;
   logic [H-1:0] prod_hi;
   logic [W-1:0] prod;
   logic [W-1:0] sum;

   // products truncated to lane width
   always_comb begin
      prod_lo = data_input[H-1:0] * weight[H-1:0];
      prod_hi = data_input[W-1:H] * weight[W-1:H];
      if (prec == PREC_HALF) begin
         prod = {prod_hi, prod_lo};
      end else begin
         prod = data_input * weight;
      end
   end

   if (accumulate != 0) begin : g_acc
      always_comb begin
         if (prec == PREC_HALF) begin
            sum[W-1:H] = prod[W-1:H] + res_mac_p[W-1:H]; // high lane on its own
            sum[H-1:0] = prod[H-1:0] + res_mac_p[H-1:0];
         end else begin
            sum = prod + res_mac_p;
         end
      end
   end else begin : g_first
      assign sum = prod; // start of the row, nothing to add
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         res_mac_n           <= '0;
         data_input_next_row <= '0;
      end else if (enable) begin
         res_mac_n           <= sum;
         data_input_next_row <= data_input; // one row down per cycle
      end
   end

endmodule

// File: hdl/mxu_pkg.sv
package mxu_pkg;

   //////////////////////////////
   // arithmetic modes
   //////////////////////////////

   // PREC_FULL: one lane over the whole word, wraps modulo 2^W
   // PREC_HALF: two lanes of W/2 bits, no carry from the low lane into the high one
   typedef enum logic {
      PREC_FULL = 1'b0,
      PREC_HALF = 1'b1
   } precision_e;

endpackage

// File: hdl/mxu_skew.sv
`include "mxu_macros.svh"

module mxu_skew #(
   parameter int lanes   = 3,
   parameter bit reverse = 1'b0
) (
   input  logic                          clk,
   input  logic                          rst_n,
   input  logic                          enable,
   input  logic [lanes*`MXU_WIDTH-1:0]   din,
   output logic [lanes*`MXU_WIDTH-1:0]   dout
);
   localparam int W = `MXU_WIDTH;

   // forward: lane n waits n cycles, builds the input wavefront
   // reverse: lane n waits lanes-n cycles, so the last row still
   // goes through one register and every result leaves together
   for (genvar n = 0; n < lanes; n++) begin : g_lane
      localparam int depth = reverse ? (lanes - n) : n;

      if (depth == 0) begin : g_pass
         assign dout[n*W +: W] = din[n*W +: W]; // lane 0 of the forward skew
      end else begin : g_delay
         logic [W-1:0] taps [depth];

         always_ff @(posedge clk) begin
            if (!rst_n) begin
               taps <= '{default: '0};
            end else if (enable) begin
               taps[0] <= din[n*W +: W];
               for (int k = 1; k < depth; k++) begin
                  taps[k] <= taps[k-1];
               end
            end
         end

         assign dout[n*W +: W] = taps[depth-1];
      end
   end

endmodule

// File: hdl/mxu_top.sv
`include "mxu_macros.svh"

module mxu_top (
   input  logic                              clk,
   input  logic                              rst_n,
   input  logic                              enable,
   input  mxu_pkg::precision_e               data_type,
   input  logic                              in_valid,
   input  logic [`MXU_COLS*`MXU_WIDTH-1:0]   input_data,
   input  logic                              w_load,
   input  logic [$clog2(`MXU_ROWS)-1:0]      w_row,
   input  logic [`MXU_WIDTH-1:0]             w_data,
   output logic [`MXU_ROWS*`MXU_WIDTH-1:0]   y,
   output logic                              out_valid,
   output logic                              busy
);
   import mxu_pkg::*;

   precision_e                            prec;
   logic [`MXU_ROWS*`MXU_WIDTH-1:0]       weights;
   logic [`MXU_COLS*`MXU_WIDTH-1:0]       skewed_cols; // wavefront into the array
   logic [`MXU_ROWS*`MXU_WIDTH-1:0]       row_res;     // still skewed by row

   mxu_ctrl ctrl_i (
      .clk       (clk),
      .rst_n     (rst_n),
      .enable    (enable),
      .in_valid  (in_valid),
      .data_type (data_type),
      .prec      (prec),
      .out_valid (out_valid),
      .busy      (busy)
   );

   mxu_weight_buf wbuf_i (
      .clk     (clk),
      .rst_n   (rst_n),
      .w_load  (w_load),
      .w_row   (w_row),
      .w_data  (w_data),
      .busy    (busy),
      .weights (weights)
   );

   mxu_skew #(
      .lanes   (`MXU_COLS),
      .reverse (1'b0)
   ) col_skew_i (
      .clk    (clk),
      .rst_n  (rst_n),
      .enable (enable),
      .din    (input_data),
      .dout   (skewed_cols)
   );

   mxu_core core_i (
      .clk        (clk),
      .rst_n      (rst_n),
      .enable     (enable),
      .prec       (prec),
      .input_data (skewed_cols),
      .weight     (weights),
      .y          (row_res)
   );

   mxu_skew #(
      .lanes   (`MXU_ROWS),
      .reverse (1'b1)
   ) row_deskew_i (
      .clk    (clk),
      .rst_n  (rst_n),
      .enable (enable),
      .din    (row_res),
      .dout   (y)
   );

endmodule

// File: hdl/mxu_weight_buf.sv
`include "mxu_macros.svh"

module mxu_weight_buf (
   input  logic                              clk,
   input  logic                              rst_n,
   input  logic                              w_load,
   input  logic [$clog2(`MXU_ROWS)-1:0]      w_row,
   input  logic [`MXU_WIDTH-1:0]             w_data,
   input  logic                              busy,
   output logic [`MXU_ROWS*`MXU_WIDTH-1:0]   weights
);
   localparam int R = `MXU_ROWS;
   localparam int W = `MXU_WIDTH;

   logic [W-1:0] w_regs [R];

   // loads only while the array is empty, so vectors in flight
   // never see a mix of old and new weights
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         w_regs <= '{default: '0};
      end else if (w_load && !busy && (w_row < R)) begin
         w_regs[w_row] <= w_data; // out of range rows are dropped
      end
   end

   always_comb begin
      for (int r = 0; r < R; r++) begin
         weights[r*W +: W] = w_regs[r];
      end
   end

endmodule

// File: include/mxu_macros.svh
`ifndef MXU_MACROS_SVH
`define MXU_MACROS_SVH

//////////////////////////////
// array geometry
//////////////////////////////

// rows = weights = result words
`define MXU_ROWS 3

// columns = input words per vector
`define MXU_COLS 3

//////////////////////////////
// datapath
//////////////////////////////

`define MXU_WIDTH 8 // keep even, half mode splits it in two lanes

// accepted input to result, in enabled cycles
`define MXU_LATENCY (`MXU_ROWS + `MXU_COLS)

`endif

// File: verification/mxu_props.sv
`include "mxu_macros.svh"

module mxu_props (
   input logic                              clk,
   input logic                              rst_n,
   input logic                              enable,
   input logic                              out_valid,
   input logic                              busy,
   input logic [`MXU_ROWS*`MXU_WIDTH-1:0]   y,
   input logic [`MXU_ROWS*`MXU_WIDTH-1:0]   weights
);

   //////////////////////////////
   // control flags
   //////////////////////////////

   reset_clears_flags: assert property (@(posedge clk) !rst_n |=> (!out_valid && !busy))
      else $error("out_valid or busy high in the cycle after reset");

   // a result can only leave a pipeline that held something
   valid_needs_busy: assert property (@(posedge clk) disable iff (!rst_n)
      out_valid |-> $past(busy))
      else $error("out_valid without busy in the cycle before");

   //////////////////////////////
   // stall and weights
   //////////////////////////////

   stall_holds_outputs: assert property (@(posedge clk) disable iff (!rst_n)
      !enable |=> ($stable(y) && $stable(out_valid)))
      else $error("y or out_valid moved on an edge with enable low");

   weights_change_idle: assert property (@(posedge clk) disable iff (!rst_n)
      !$stable(weights) |-> !$past(busy))
      else $error("weights changed while the array was busy");

endmodule

bind mxu_top mxu_props props_i (
   .clk       (clk),
   .rst_n     (rst_n),
   .enable    (enable),
   .out_valid (out_valid),
   .busy      (busy),
   .y         (y),
   .weights   (weights) // internal to mxu_top
);

// File: verification/mxu_tb.sv
`include "mxu_macros.svh"

module mxu_tb;
   import mxu_pkg::*;

   localparam int R       = `MXU_ROWS;
   localparam int C       = `MXU_COLS;
   localparam int W       = `MXU_WIDTH;
   localparam int H       = W / 2;
   localparam int L       = `MXU_LATENCY;
   localparam int TIMEOUT = 8 * L + 50;
   localparam logic [W-1:0] LANE_MSB = {2{1'b1, {(H-1){1'b0}}}}; // top bit of each half lane

   logic                 clk;
   logic                 rst_n;
   logic                 enable;
   precision_e           data_type;
   logic                 in_valid;
   logic [C*W-1:0]       input_data;
   logic                 w_load;
   logic [$clog2(R)-1:0] w_row;
   logic [W-1:0]         w_data;
   logic [R*W-1:0]       y;
   logic                 out_valid;
   logic                 busy;

   integer seed;

   // scoreboard state touched only on rising edges
   logic [R*W-1:0] exp_q [$];
   int             stamp_q [$];    // enabled edge count at acceptance
   logic [W-1:0]   model_w [R];
   precision_e     model_prec;
   logic           prev_en;
   logic           tail_pending;   // popped result still sits in the last stage
   int             en_cycles;
   int             results;

   mxu_top mxu_top_i (
      .clk        (clk),
      .rst_n      (rst_n),
      .enable     (enable),
      .data_type  (data_type),
      .in_valid   (in_valid),
      .input_data (input_data),
      .w_load     (w_load),
      .w_row      (w_row),
      .w_data     (w_data),
      .y          (y),
      .out_valid  (out_valid),
      .busy       (busy)
   );

   always #2 clk = ~clk;

   //////////////////////////////
   // reporting and compares
   //////////////////////////////

   task automatic fail_run(input string msg);
      $display("%s", msg);
      $display("FAIL: see errors above");
      $fatal(1, "stopped at first error");
   endtask

   task automatic check_y(input logic [R*W-1:0] got, input logic [R*W-1:0] exp);
      if (got !== exp)
         fail_run($sformatf("FAILED at time %0t: y is %h, expected %h", $time, got, exp));
   endtask

   task automatic check_busy(input logic got, input logic exp);
      if (got !== exp)
         fail_run($sformatf("FAILED at time %0t: busy is %b, expected %b", $time, got, exp));
   endtask

   task automatic check_valid(input logic got, input logic exp);
      if (got !== exp)
         fail_run($sformatf("FAILED at time %0t: out_valid is %b, expected %b", $time, got, exp));
   endtask

   task automatic check_count(input int got, input int exp, input string what);
      if (got != exp)
         fail_run($sformatf("FAILED at time %0t: %s is %0d, expected %0d", $time, what, got, exp));
   endtask

   //////////////////////////////
   // reference model
   //////////////////////////////

   // y_i = w_i * sum of x_j per lane with each lane wrapping on its own
   function automatic logic [R*W-1:0] ref_y(input logic [C*W-1:0] vec,
                                            input logic [W-1:0] w [R],
                                            input precision_e p);
      logic [R*W-1:0] res;
      int sum_full;
      int sum_lo;
      int sum_hi;
      sum_full = 0;
      sum_lo   = 0;
      sum_hi   = 0;
      for (int j = 0; j < C; j++) begin
         sum_full += int'(vec[j*W +: W]);
         sum_lo   += int'(vec[j*W +: H]);
         sum_hi   += int'(vec[j*W+H +: H]);
      end
      for (int r = 0; r < R; r++) begin
         if (p == PREC_HALF) begin
            res[r*W +: H]   = (int'(w[r][H-1:0]) * sum_lo) % (1 << H);
            res[r*W+H +: H] = (int'(w[r][W-1:H]) * sum_hi) % (1 << H);
         end else begin
            res[r*W +: W] = (int'(w[r]) * sum_full) % (1 << W);
         end
      end
      return res;
   endfunction

   // samples pre-edge values driven half a cycle earlier
   always @(posedge clk) begin : scoreboard
      logic           model_busy;
      logic [R*W-1:0] exp_y;
      int             stamp;
      if (!rst_n) begin
         exp_q.delete();
         stamp_q.delete();
         model_w      = '{default: '0};
         model_prec   = PREC_FULL;
         prev_en      = 1'b0;
         tail_pending = 1'b0;
         en_cycles    = 0;
      end else begin
         model_busy = (exp_q.size() != 0) || tail_pending;
         check_busy(busy, model_busy);
         if (prev_en && out_valid) begin // fresh result from the last enabled edge
            if (exp_q.size() == 0)
               fail_run("out_valid went high with no vector in flight");
            exp_y = exp_q.pop_front();
            stamp = stamp_q.pop_front();
            check_y(y, exp_y);
            check_count(en_cycles - stamp, L, "latency in enabled cycles");
            tail_pending = 1'b1;
            results++;
         end
         if (enable) begin
            if (in_valid) begin
               exp_q.push_back(ref_y(input_data, model_w, model_prec));
               stamp_q.push_back(en_cycles);
            end
            en_cycles++;
            tail_pending = 1'b0;
            if (!model_busy)
               model_prec = data_type;
         end
         if (w_load && !model_busy && (w_row < R))
            model_w[w_row] = w_data; // loads while busy are dropped
         prev_en = enable;
      end
   end

   //////////////////////////////
   // stimulus helpers
   //////////////////////////////

   function automatic logic [C*W-1:0] rand_vector(input logic [W-1:0] or_mask);
      logic [C*W-1:0] v;
      for (int j = 0; j < C; j++)
         v[j*W +: W] = $random(seed) | or_mask;
      return v;
   endfunction

   task automatic random_weights(output logic [W-1:0] w [R], input logic [W-1:0] or_mask);
      for (int r = 0; r < R; r++)
         w[r] = $random(seed) | or_mask;
   endtask

   task automatic wait_idle();
      int n;
      n = 0;
      while (busy) begin
         @(negedge clk);
         n++;
         if (n > TIMEOUT) fail_run("timeout waiting for idle");
      end
   endtask

   task automatic wait_out_valid();
      int n;
      n = 0;
      do begin
         @(negedge clk);
         n++;
         if (n > TIMEOUT) fail_run("timeout waiting for out_valid");
      end while (!out_valid);
   endtask

   // holds the vector until an enabled edge takes it
   task automatic send_vector(input logic [C*W-1:0] vec, input int stall_pct);
      logic go;
      int   n;
      go = 1'b0;
      n  = 0;
      while (!go) begin
         @(negedge clk);
         in_valid   = 1'b1;
         input_data = vec;
         go         = ($unsigned($random(seed)) % 100) >= stall_pct;
         enable     = go;
         n++;
         if (n > TIMEOUT) fail_run("timeout waiting for an enabled edge to take a vector");
      end
   endtask

   task automatic end_stream();
      @(negedge clk);
      in_valid = 1'b0;
      enable   = 1'b1;
   endtask

   task automatic load_weights(input logic [W-1:0] w [R]);
      wait_idle();
      for (int r = 0; r < R; r++) begin
         @(negedge clk);
         w_load = 1'b1;
         w_row  = r;
         w_data = w[r];
      end
      @(negedge clk);
      w_load = 1'b0;
   endtask

   task automatic set_precision(input precision_e p);
      wait_idle();
      @(negedge clk);
      data_type = p;
      repeat (2) @(negedge clk); // latched while idle before the next vector
   endtask

   // weight write attempt while vectors are in flight
   task automatic locked_load();
      @(negedge clk);
      in_valid = 1'b0;
      enable   = 1'b1;
      check_busy(busy, 1'b1);
      w_load = 1'b1;
      w_row  = '0;
      w_data = ~model_w[0];
      @(negedge clk);
      w_load = 1'b0;
   endtask

   task automatic stream(input int n, input int stall_pct, input logic [W-1:0] or_mask,
                         input int lock_at);
      int r0;
      r0 = results;
      for (int k = 0; k < n; k++) begin
         if (k == lock_at) locked_load();
         send_vector(rand_vector(or_mask), stall_pct);
      end
      end_stream();
      wait_idle();
      check_count(results - r0, n, "result count");
   endtask

   //////////////////////////////
   // test sequence
   //////////////////////////////

   initial begin
      logic [W-1:0] w_new [R];
      int           r0;
      clk        = 1'b0;
      rst_n      = 1'b0;
      enable     = 1'b1;
      data_type  = PREC_FULL;
      in_valid   = 1'b0;
      input_data = '0;
      w_load     = 1'b0;
      w_row      = '0;
      w_data     = '0;
      seed       = 92222;
      results    = 0;
      repeat (4) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;

      // zero weights after reset give zero results
      @(negedge clk);
      check_busy(busy, 1'b0);
      check_valid(out_valid, 1'b0);
      send_vector(rand_vector('0), 0);
      end_stream();
      wait_out_valid();
      check_y(y, {(R*W){1'b0}});
      wait_idle();

      // single vector in full precision
      random_weights(w_new, '0);
      load_weights(w_new);
      r0 = results;
      send_vector(rand_vector('0), 0);
      end_stream();
      wait_out_valid();
      wait_idle();
      check_count(results - r0, 1, "result count");

      stream(40, 0, '0, -1); // back to back

      // half precision with lane overflow
      set_precision(PREC_HALF);
      random_weights(w_new, LANE_MSB);
      load_weights(w_new);
      stream(30, 0, LANE_MSB, -1);

      // stalls and a weight write that must be ignored
      set_precision(PREC_FULL);
      random_weights(w_new, '0);
      load_weights(w_new);
      stream(40, 30, '0, 12);

      $display("PASS: all tests");
      $finish;
   end

endmodule
